//--- verilog/sha_config.svh
`ifndef SHA_CONFIG_SVH
`define SHA_CONFIG_SVH

// Rounds in one SHA-256 compression.
`define SHA_ROUNDS 64

// Registers per round stage unless the top overrides it.
`define SHA_ROUND_DEPTH 1

// Width of one SHA-256 word.
`define SHA_WORD_W 32

`endif

//--- verilog/sha_pkg.sv
`default_nettype none

`include "sha_config.svh"

package sha_pkg;

	// Working variables a to h, with a in the top bits.
	typedef struct packed {
		logic [`SHA_WORD_W-1:0] a;
		logic [`SHA_WORD_W-1:0] b;
		logic [`SHA_WORD_W-1:0] c;
		logic [`SHA_WORD_W-1:0] d;
		logic [`SHA_WORD_W-1:0] e;
		logic [`SHA_WORD_W-1:0] f;
		logic [`SHA_WORD_W-1:0] g;
		logic [`SHA_WORD_W-1:0] h;
	} hash_state_t;

	// Sixteen message words; word 0 is the oldest and sits in the top bits,
	// so a SHA-256 block maps onto it without reordering.
	typedef logic [0:15][`SHA_WORD_W-1:0] msg_window_t;

	localparam logic [0:63][`SHA_WORD_W-1:0] K_TABLE = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam hash_state_t SHA_IV = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic logic [`SHA_WORD_W-1:0] sha_k(input int unsigned idx);
		return K_TABLE[idx];
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_rotr(input logic [`SHA_WORD_W-1:0] x,
		input int unsigned n);
		return (x >> n) | (x << (`SHA_WORD_W - n));
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_bsig0(input logic [`SHA_WORD_W-1:0] x);
		return sha_rotr(x, 2) ^ sha_rotr(x, 13) ^ sha_rotr(x, 22);
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_bsig1(input logic [`SHA_WORD_W-1:0] x);
		return sha_rotr(x, 6) ^ sha_rotr(x, 11) ^ sha_rotr(x, 25);
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_ssig0(input logic [`SHA_WORD_W-1:0] x);
		return sha_rotr(x, 7) ^ sha_rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_ssig1(input logic [`SHA_WORD_W-1:0] x);
		return sha_rotr(x, 17) ^ sha_rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_ch(input logic [`SHA_WORD_W-1:0] x,
		input logic [`SHA_WORD_W-1:0] y, input logic [`SHA_WORD_W-1:0] z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic logic [`SHA_WORD_W-1:0] sha_maj(input logic [`SHA_WORD_W-1:0] x,
		input logic [`SHA_WORD_W-1:0] y, input logic [`SHA_WORD_W-1:0] z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

`default_nettype wire

//--- verilog/sha_round_stage.sv
`default_nettype none
`timescale 1ns/1ps

module sha_round_stage #(
	parameter int ROUND = 0,
	parameter bit EXPAND = 1'b0,
	parameter int DEPTH = 1
) (
	input wire logic clk,
	input sha_pkg::hash_state_t state_i,
	input sha_pkg::msg_window_t window_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::msg_window_t window_o
);

	localparam logic [31:0] K = sha_pkg::sha_k(ROUND);

	sha_pkg::hash_state_t st_d;
	sha_pkg::msg_window_t win_d;
	sha_pkg::hash_state_t st_q [DEPTH];
	sha_pkg::msg_window_t win_q [DEPTH];
	logic [31:0] w_new;
	logic [31:0] w_round;
	logic [31:0] t1;
	logic [31:0] t2;

	// In the first 16 rounds the window holds the block itself and word 0 is consumed.
	// Later the window holds the last 16 schedule words and the round uses the new one.
	always_comb begin
		w_new = sha_pkg::sha_ssig1(window_i[14]) + window_i[9] +
			sha_pkg::sha_ssig0(window_i[1]) + window_i[0];
		w_round = EXPAND ? w_new : window_i[0];

		t1 = state_i.h + sha_pkg::sha_bsig1(state_i.e) +
			sha_pkg::sha_ch(state_i.e, state_i.f, state_i.g) + K + w_round;
		t2 = sha_pkg::sha_bsig0(state_i.a) + sha_pkg::sha_maj(state_i.a, state_i.b, state_i.c);

		st_d.a = t1 + t2;
		st_d.b = state_i.a;
		st_d.c = state_i.b;
		st_d.d = state_i.c;
		st_d.e = state_i.d + t1;
		st_d.f = state_i.e;
		st_d.g = state_i.f;
		st_d.h = state_i.g;

		// The word just used goes to the top either way.
		for (int i = 0; i < 15; i++) begin
			win_d[i] = window_i[i+1];
		end
		win_d[15] = w_round;
	end

	always_ff @(posedge clk) begin
		st_q[0] <= st_d;
		win_q[0] <= win_d;
		for (int i = 1; i < DEPTH; i++) begin
			st_q[i] <= st_q[i-1];
			win_q[i] <= win_q[i-1];
		end
	end

	assign state_o = st_q[DEPTH-1];
	assign window_o = win_q[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/sha_delay_line.sv
`default_nettype none
`timescale 1ns/1ps

module sha_delay_line #(
	parameter type T = logic,
	parameter int DELAY = 1
) (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input T data_i,
	output logic valid_o,
	output T data_o
);

	logic valid_q [DELAY];
	T data_q [DELAY];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DELAY; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= valid_i;
			for (int i = 1; i < DELAY; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q[0] <= data_i;
		for (int i = 1; i < DELAY; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign valid_o = valid_q[DELAY-1];
	assign data_o = data_q[DELAY-1];

	// Every stage is cleared, so the output must be known from the first cycle out of reset.
	valid_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$isunknown(valid_o));

endmodule

`default_nettype wire

//--- verilog/sha_compress_pipeline.sv
`default_nettype none
`timescale 1ns/1ps

`include "sha_config.svh"

module sha_compress_pipeline #(
	parameter int DEPTH = 1
) (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input sha_pkg::hash_state_t state_i,
	input sha_pkg::msg_window_t window_i,
	output logic valid_o,
	output sha_pkg::hash_state_t state_o
);

	sha_pkg::hash_state_t st [0:`SHA_ROUNDS];
	sha_pkg::msg_window_t win [0:`SHA_ROUNDS];

	assign st[0] = state_i;
	assign win[0] = window_i;

	// Rounds 0 to 15 read the block directly, the rest run the message expander.
	for (genvar r = 0; r < `SHA_ROUNDS; r++) begin : g_round
		sha_round_stage #(
			.ROUND(r),
			.EXPAND(r >= 16),
			.DEPTH(DEPTH)
		) round0 (
			.clk(clk),
			.state_i(st[r]),
			.window_i(win[r]),
			.state_o(st[r+1]),
			.window_o(win[r+1])
		);
	end

	assign state_o = st[`SHA_ROUNDS];

	// Only the strobe travels here; the payload is carried by the round stages.
	sha_delay_line #(
		.T(logic),
		.DELAY(`SHA_ROUNDS * DEPTH)
	) valid_delay (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.data_i(1'b0),
		.valid_o(valid_o),
		.data_o()
	);

endmodule

`default_nettype wire

//--- verilog/sha_pad_hash.sv
`default_nettype none
`timescale 1ns/1ps

module sha_pad_hash (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic valid_i,
	input sha_pkg::hash_state_t state_i,
	input sha_pkg::hash_state_t feed_i,
	output logic valid_o,
	output sha_pkg::msg_window_t window_o
);

	logic [7:0][31:0] st_w;
	logic [7:0][31:0] fd_w;
	sha_pkg::msg_window_t blk_d;

	assign st_w = state_i;
	assign fd_w = feed_i;

	// The 256-bit digest is a one-block message of length 256 bits.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			blk_d[i] = st_w[7-i] + fd_w[7-i];
		end
		blk_d[8] = 32'h8000_0000;
		for (int i = 9; i < 15; i++) begin
			blk_d[i] = '0;
		end
		blk_d[15] = 32'd256;
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		window_o <= blk_d;
	end

	padding_const_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o |-> (window_o[8] == 32'h8000_0000) && (window_o[9:14] == '0) &&
			(window_o[15] == 32'd256));

endmodule

`default_nettype wire

//--- verilog/sha_double_hash_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "sha_config.svh"

module sha_double_hash_core #(
	parameter int ROUND_PIPELINE_DEPTH = `SHA_ROUND_DEPTH
) (
	input wire logic clk,
	input wire logic rst_n_i,
	input wire logic [8*`SHA_WORD_W-1:0] midstate_i,
	input wire logic [16*`SHA_WORD_W-1:0] block_i,
	input wire logic [`SHA_WORD_W-1:0] difficulty_i,
	input wire logic valid_i,
	output logic [8*`SHA_WORD_W-1:0] doublehash_o,
	output logic [`SHA_WORD_W-1:0] difficulty_o,
	output logic valid_o
);

	localparam int HASH_DELAY = `SHA_ROUNDS * ROUND_PIPELINE_DEPTH;

	sha_pkg::hash_state_t mid_state;
	sha_pkg::hash_state_t mid_delayed;
	sha_pkg::hash_state_t c1_state;
	sha_pkg::hash_state_t c2_state;
	sha_pkg::msg_window_t blk_window;
	sha_pkg::msg_window_t pad_window;
	logic c1_valid;
	logic pad_valid;
	logic c2_valid;
	logic diff_valid;
	logic [7:0][`SHA_WORD_W-1:0] c2_w;
	logic [7:0][`SHA_WORD_W-1:0] iv_w;
	logic [7:0][`SHA_WORD_W-1:0] sum_w;

	assign mid_state = sha_pkg::hash_state_t'(midstate_i);
	assign blk_window = sha_pkg::msg_window_t'(block_i);

	sha_compress_pipeline #(.DEPTH(ROUND_PIPELINE_DEPTH)) comp1 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.state_i(mid_state),
		.window_i(blk_window),
		.valid_o(c1_valid),
		.state_o(c1_state)
	);

	// The midstate waits here for the first compression to finish.
	sha_delay_line #(.T(sha_pkg::hash_state_t), .DELAY(HASH_DELAY)) mid_delay (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.data_i(mid_state),
		.valid_o(),
		.data_o(mid_delayed)
	);

	sha_pad_hash pad0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(c1_valid),
		.state_i(c1_state),
		.feed_i(mid_delayed),
		.valid_o(pad_valid),
		.window_o(pad_window)
	);

	sha_compress_pipeline #(.DEPTH(ROUND_PIPELINE_DEPTH)) comp2 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(pad_valid),
		.state_i(sha_pkg::SHA_IV),
		.window_i(pad_window),
		.valid_o(c2_valid),
		.state_o(c2_state)
	);

	// Two compressions, the pad stage and the output register.
	sha_delay_line #(.T(logic [`SHA_WORD_W-1:0]), .DELAY(2 * HASH_DELAY + 2)) diff_delay (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.valid_i(valid_i),
		.data_i(difficulty_i),
		.valid_o(diff_valid),
		.data_o(difficulty_o)
	);

	assign c2_w = c2_state;
	assign iv_w = sha_pkg::SHA_IV;

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum_w[i] = c2_w[i] + iv_w[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= c2_valid;
		end
	end

	always_ff @(posedge clk) begin
		doublehash_o <= sum_w;
	end

	diff_align_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o == diff_valid);

endmodule

`default_nettype wire

//--- sim/sha_tb_model.svh
`ifndef SHA_TB_MODEL_SVH
`define SHA_TB_MODEL_SVH

// SHA-256 round constants.
localparam logic [31:0] REF_K [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
	32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
	32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
	32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
	32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
	32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [255:0] REF_IV =
	256'h6a09e667_bb67ae85_3c6ef372_a54ff53a_510e527f_9b05688c_1f83d9ab_5be0cd19;

function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One compression of a 512-bit block, feed-forward included.
function automatic logic [255:0] compress_block(input logic [255:0] hin, input logic [511:0] blk);
	logic [31:0] w [64];
	logic [31:0] v [8];
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	logic [255:0] hout;
	for (int t = 0; t < 16; t++) begin
		w[t] = blk[511-32*t -: 32];
	end
	for (int t = 16; t < 64; t++) begin
		s0 = rotr32(w[t-15], 7) ^ rotr32(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = rotr32(w[t-2], 17) ^ rotr32(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	for (int i = 0; i < 8; i++) begin
		v[i] = hin[255-32*i -: 32];
	end
	for (int t = 0; t < 64; t++) begin
		s1 = rotr32(v[4], 6) ^ rotr32(v[4], 11) ^ rotr32(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + REF_K[t] + w[t];
		s0 = rotr32(v[0], 2) ^ rotr32(v[0], 13) ^ rotr32(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) begin
		hout[255-32*i -: 32] = hin[255-32*i -: 32] + v[i];
	end
	return hout;
endfunction

// The first digest is padded as a 256-bit message and hashed again from the IV.
function automatic logic [255:0] double_hash(input logic [255:0] midstate,
	input logic [511:0] blk);
	logic [255:0] first;
	first = compress_block(midstate, blk);
	return compress_block(REF_IV, {first, 32'h8000_0000, 192'd0, 32'd256});
endfunction

`endif

//--- sim/tb_sha_double_hash_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_sha_double_hash_core;

	`include "sha_tb_model.svh"

	localparam int LATENCY = 130;
	localparam int DRAIN_LIMIT = 400;
	localparam logic [511:0] ABC_BLOCK = {32'h6162_6380, 448'd0, 32'h0000_0018};
	localparam logic [255:0] ABC_DIGEST =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

	logic clk;
	logic rst_n_i;
	logic [255:0] midstate_i;
	logic [511:0] block_i;
	logic [31:0] difficulty_i;
	logic valid_i;
	logic [255:0] doublehash_o;
	logic [31:0] difficulty_o;
	logic valid_o;

	// Expected results in job order, with the cycle count at which each job was driven.
	logic [255:0] exp_hash_q [$];
	logic [31:0] exp_diff_q [$];
	int exp_cycle_q [$];
	logic head_valid;
	logic [255:0] head_hash;
	logic [31:0] head_diff;
	int head_cycle;
	int cycle_cnt;
	logic rst_q;
	int seed;
	int jobs_sent;
	int results_seen;
	int value_errors;
	int timeouts;
	logic [255:0] mid;
	logic [511:0] blk;
	logic [31:0] diff;
	int gap;

	sha_double_hash_core #(.ROUND_PIPELINE_DEPTH(1)) dut0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.midstate_i(midstate_i),
		.block_i(block_i),
		.difficulty_i(difficulty_i),
		.valid_i(valid_i),
		.doublehash_o(doublehash_o),
		.difficulty_o(difficulty_o),
		.valid_o(valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic refresh_head();
		head_valid = exp_hash_q.size() > 0;
		if (head_valid) begin
			head_hash = exp_hash_q[0];
			head_diff = exp_diff_q[0];
			head_cycle = exp_cycle_q[0];
		end
	endtask

	// Called on a falling edge; the job is taken on the next rising edge.
	task automatic send_job(input logic [255:0] m, input logic [511:0] b, input logic [31:0] d);
		midstate_i = m;
		block_i = b;
		difficulty_i = d;
		valid_i = 1'b1;
		exp_hash_q.push_back(double_hash(m, b));
		exp_diff_q.push_back(d);
		exp_cycle_q.push_back(cycle_cnt);
		refresh_head();
		jobs_sent++;
		@(negedge clk);
		valid_i = 1'b0;
	endtask

	task automatic random_job(output logic [255:0] m, output logic [511:0] b,
		output logic [31:0] d);
		for (int i = 0; i < 8; i++) begin
			m[32*i +: 32] = $random(seed);
		end
		for (int i = 0; i < 16; i++) begin
			b[32*i +: 32] = $random(seed);
		end
		d = $random(seed);
	endtask

	task automatic wait_drain(input string what);
		int waited;
		waited = 0;
		while (exp_hash_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_hash_q.size() > 0) begin
			$display("Timeout: %0d result(s) of the %s never came out on valid_o",
				exp_hash_q.size(), what);
			timeouts++;
			exp_hash_q.delete();
			exp_diff_q.delete();
			exp_cycle_q.delete();
			refresh_head();
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		rst_q <= !rst_n_i;
		if (rst_n_i && valid_o && exp_hash_q.size() > 0) begin
			void'(exp_hash_q.pop_front());
			void'(exp_diff_q.pop_front());
			void'(exp_cycle_q.pop_front());
			refresh_head();
		end
		if (rst_n_i && valid_o) begin
			results_seen++;
		end
	end

	no_spurious_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o |-> head_valid)
		else begin
			$display("CHECK FAILED at %0t: valid_o high with no job outstanding", $time);
			value_errors++;
		end

	hash_match_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		(valid_o && head_valid) |-> doublehash_o == head_hash)
		else begin
			$display("CHECK FAILED at %0t: hash %h, expected %h", $time,
				$sampled(doublehash_o), $sampled(head_hash));
			value_errors++;
		end

	diff_match_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		(valid_o && head_valid) |-> difficulty_o == head_diff)
		else begin
			$display("CHECK FAILED at %0t: difficulty %h, expected %h", $time,
				$sampled(difficulty_o), $sampled(head_diff));
			value_errors++;
		end

	// The counter lags one edge behind, so a job driven at count n shows up at count n+130.
	latency_a: assert property (@(posedge clk) disable iff (!rst_n_i)
		(valid_o && head_valid) |-> cycle_cnt == head_cycle + LATENCY)
		else begin
			$display("CHECK FAILED at %0t: result after %0d cycles, expected %0d", $time,
				$sampled(cycle_cnt) - $sampled(head_cycle), LATENCY);
			value_errors++;
		end

	reset_quiet_a: assert property (@(posedge clk) (!rst_n_i && rst_q) |-> !valid_o)
		else begin
			$display("CHECK FAILED at %0t: valid_o high during reset", $time);
			value_errors++;
		end

	initial begin
		seed = 65055;
		cycle_cnt = 0;
		rst_q = 1'b0;
		head_valid = 1'b0;
		head_hash = '0;
		head_diff = '0;
		head_cycle = 0;
		jobs_sent = 0;
		results_seen = 0;
		value_errors = 0;
		timeouts = 0;
		rst_n_i = 1'b0;
		midstate_i = '0;
		block_i = '0;
		difficulty_i = '0;
		valid_i = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;

		// The model itself must reproduce the published digest of "abc".
		assert (compress_block(REF_IV, ABC_BLOCK) == ABC_DIGEST)
		else begin
			$display("CHECK FAILED at %0t: reference model digest of abc is wrong", $time);
			value_errors++;
		end

		// Nothing may come out while the core is idle.
		repeat (LATENCY + 10) @(negedge clk);

		send_job(REF_IV, ABC_BLOCK, 32'h1703_a30c);
		wait_drain("known vector");

		for (int j = 0; j < 40; j++) begin
			random_job(mid, blk, diff);
			send_job(mid, blk, diff);
		end
		wait_drain("back-to-back stream");

		for (int j = 0; j < 30; j++) begin
			random_job(mid, blk, diff);
			send_job(mid, blk, diff);
			gap = $random(seed) & 7;
			repeat (gap) @(negedge clk);
		end
		wait_drain("gapped stream");
		repeat (20) @(negedge clk);

		if (results_seen != jobs_sent) begin
			$display("CHECK FAILED at %0t: %0d results for %0d jobs", $time,
				results_seen, jobs_sent);
			value_errors++;
		end
		$display("jobs %0d, results %0d, value errors %0d, timeouts %0d",
			jobs_sent, results_seen, value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
+incdir+sim
verilog/sha_pkg.sv
verilog/sha_round_stage.sv
verilog/sha_delay_line.sv
verilog/sha_compress_pipeline.sv
verilog/sha_pad_hash.sv
verilog/sha_double_hash_core.sv
sim/tb_sha_double_hash_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the run from its log.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_sha_double_hash_core -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }
grep -q "FAIL: see errors above" sim.log \
	&& { echo "Simulation failed"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }
